/* coherencePkg.sv */
package coherencePkg;

	// MOESIF line states
	typedef enum logic [2:0] {
		INVALID,
		SHARED,
		EXCLUSIVE,
		OWNED,
		MODIFIED,
		FORWARD
	} CacheState;

	typedef enum logic [1:0] {
		NONE,
		BUS_READ,
		BUS_READ_EXCLUSIVE,
		BUS_UPGRADE
	} BusCommand;

	typedef enum logic [2:0] {
		WAITING_FOR_REQUEST,
		WRITING_BACK,
		READING_BLOCK,
		UPGRADING,
		SERVE_REQUEST_FINISH
	} CpuControllerState;

	// default geometry: 16 lines of 4 words
	localparam int DEFAULT_ADDRESS_WIDTH = 16;
	localparam int DEFAULT_INDEX_WIDTH = 4;
	localparam int DEFAULT_OFFSET_WIDTH = 2;
	localparam int DEFAULT_DATA_WIDTH = 16;

endpackage

/* memoryIf.sv */
`timescale 1ns/10ps

interface MemoryInterface import coherencePkg::*; #(
	parameter int ADDRESS_WIDTH = DEFAULT_ADDRESS_WIDTH,
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH
);

	logic [ADDRESS_WIDTH-1:0] address;
	logic [DATA_WIDTH-1:0] dataOut;
	logic [DATA_WIDTH-1:0] dataIn;
	logic readEnabled;
	logic writeEnabled;
	logic functionComplete;

	modport master (
		output address, dataOut, readEnabled, writeEnabled,
		input dataIn, functionComplete
	);

	modport slave (
		input address, dataOut, readEnabled, writeEnabled,
		output dataIn, functionComplete
	);

endinterface

/* cacheIf.sv */
`timescale 1ns/10ps

interface CacheInterface import coherencePkg::*; #(
	parameter int ADDRESS_WIDTH = DEFAULT_ADDRESS_WIDTH,
	parameter int INDEX_WIDTH = DEFAULT_INDEX_WIDTH,
	parameter int OFFSET_WIDTH = DEFAULT_OFFSET_WIDTH,
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH
);

	localparam int TAG_WIDTH = ADDRESS_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

	// cpu side
	logic [TAG_WIDTH-1:0] cpuTag;
	logic [INDEX_WIDTH-1:0] cpuIndex;
	logic [OFFSET_WIDTH-1:0] cpuOffset;
	logic [DATA_WIDTH-1:0] cpuDataIn;
	logic [DATA_WIDTH-1:0] cpuDataOut;
	CacheState cpuStateIn;
	CacheState cpuStateOut;
	logic [TAG_WIDTH-1:0] cpuTagOut;
	logic cpuHit;
	logic cpuWriteData;
	logic cpuWriteTag;
	logic cpuWriteState;

	// snoop side
	logic [TAG_WIDTH-1:0] snoopTag;
	logic [INDEX_WIDTH-1:0] snoopIndex;
	CacheState snoopStateOut;
	logic snoopHit;
	CacheState snoopStateIn;
	logic snoopWriteState;

	modport controller (
		output cpuTag, cpuIndex, cpuOffset, cpuDataIn, cpuStateIn,
		output cpuWriteData, cpuWriteTag, cpuWriteState,
		input cpuDataOut, cpuStateOut, cpuTagOut, cpuHit
	);

	modport snooper (
		output snoopTag, snoopIndex, snoopStateIn, snoopWriteState,
		input snoopStateOut, snoopHit
	);

	modport store (
		input cpuTag, cpuIndex, cpuOffset, cpuDataIn, cpuStateIn,
		input cpuWriteData, cpuWriteTag, cpuWriteState,
		output cpuDataOut, cpuStateOut, cpuTagOut, cpuHit,
		input snoopTag, snoopIndex, snoopStateIn, snoopWriteState,
		output snoopStateOut, snoopHit
	);

endinterface

/* cacheStore.sv */
`timescale 1ns/10ps

module cacheStore import coherencePkg::*; #(
	parameter int ADDRESS_WIDTH = DEFAULT_ADDRESS_WIDTH,
	parameter int INDEX_WIDTH = DEFAULT_INDEX_WIDTH,
	parameter int OFFSET_WIDTH = DEFAULT_OFFSET_WIDTH,
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH
) (
	input logic clock,
	input logic reset,
	CacheInterface.store store
);

	localparam int TAG_WIDTH = ADDRESS_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;
	localparam int LINES = 2 ** INDEX_WIDTH;
	localparam int WORDS = 2 ** (INDEX_WIDTH + OFFSET_WIDTH);

	logic [TAG_WIDTH-1:0] tagArray [LINES];
	CacheState stateArray [LINES];
	logic [DATA_WIDTH-1:0] dataArray [WORDS];

	logic [INDEX_WIDTH-1:0] sweepIndex;
	logic sweeping;

	// combinational lookups on both ports
	assign store.cpuStateOut = stateArray[store.cpuIndex];
	assign store.cpuTagOut = tagArray[store.cpuIndex];
	assign store.cpuDataOut = dataArray[{store.cpuIndex, store.cpuOffset}];
	assign store.cpuHit = (store.cpuStateOut != INVALID) && (store.cpuTagOut == store.cpuTag);

	assign store.snoopStateOut = stateArray[store.snoopIndex];
	assign store.snoopHit = (store.snoopStateOut != INVALID)
		&& (tagArray[store.snoopIndex] == store.snoopTag);

	always_ff @(posedge clock) begin
		if (reset) begin
			sweepIndex <= '0;
			sweeping <= 1'b1;
		end else if (sweeping) begin
			// one line per cycle back to invalid
			stateArray[sweepIndex] <= INVALID;
			sweepIndex <= sweepIndex + 1'b1;
			sweeping <= !(&sweepIndex);
		end else begin
			if (store.cpuWriteState) begin
				stateArray[store.cpuIndex] <= store.cpuStateIn;
			end
			// snoop update comes last and overrides a cpu write to the same line
			if (store.snoopWriteState) begin
				stateArray[store.snoopIndex] <= store.snoopStateIn;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (store.cpuWriteTag) begin
			tagArray[store.cpuIndex] <= store.cpuTag;
		end
		if (store.cpuWriteData) begin
			dataArray[{store.cpuIndex, store.cpuOffset}] <= store.cpuDataIn;
		end
	end

	// both controllers must stay quiet until the sweep is over
	assert property (@(posedge clock) disable iff (reset)
		sweeping |-> !(store.cpuWriteState || store.cpuWriteTag || store.cpuWriteData
			|| store.snoopWriteState));

endmodule

/* cpuController.sv */
`timescale 1ns/10ps

module cpuController import coherencePkg::*; #(
	parameter int ADDRESS_WIDTH = DEFAULT_ADDRESS_WIDTH,
	parameter int INDEX_WIDTH = DEFAULT_INDEX_WIDTH,
	parameter int OFFSET_WIDTH = DEFAULT_OFFSET_WIDTH,
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH
) (
	input logic clock,
	input logic reset,
	input logic [ADDRESS_WIDTH-1:0] cpuAddress,
	input logic [DATA_WIDTH-1:0] cpuWriteData,
	input logic cpuRead,
	input logic cpuWrite,
	output logic [DATA_WIDTH-1:0] cpuReadData,
	output logic cpuDone,
	MemoryInterface.master mem,
	CacheInterface.controller cache,
	output BusCommand busCommand,
	output logic busRequest,
	input logic busGrant,
	input logic sharedIn
);

	localparam int TAG_WIDTH = ADDRESS_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

	CpuControllerState state;
	BusCommand pendingCommand;
	logic granted;
	logic [OFFSET_WIDTH-1:0] wordCounter;
	logic [INDEX_WIDTH:0] sweepCount;

	logic [TAG_WIDTH-1:0] addrTag;
	logic [INDEX_WIDTH-1:0] addrIndex;
	logic [OFFSET_WIDTH-1:0] addrOffset;
	logic sweepDone;
	logic ownsLine;
	logic dirtyVictim;
	logic lastWord;
	logic blockTransfer;
	logic fillWrite;
	logic hitWrite;
	logic upgradeWrite;

	assign addrTag = cpuAddress[ADDRESS_WIDTH-1 -: TAG_WIDTH];
	assign addrIndex = cpuAddress[OFFSET_WIDTH +: INDEX_WIDTH];
	assign addrOffset = cpuAddress[OFFSET_WIDTH-1:0];

	// store clears its states during the first 2^INDEX_WIDTH cycles
	assign sweepDone = sweepCount[INDEX_WIDTH];

	assign ownsLine = (cache.cpuStateOut == EXCLUSIVE) || (cache.cpuStateOut == MODIFIED);
	assign dirtyVictim = (cache.cpuStateOut == MODIFIED) || (cache.cpuStateOut == OWNED);
	assign lastWord = &wordCounter;
	assign blockTransfer = (state == WRITING_BACK) || (state == READING_BLOCK);

	assign fillWrite = (state == READING_BLOCK) && granted && mem.functionComplete;
	assign hitWrite = (state == WAITING_FOR_REQUEST) && sweepDone && cpuWrite
		&& cache.cpuHit && ownsLine;
	assign upgradeWrite = (state == UPGRADING) && cache.cpuHit && busGrant;

	assign cache.cpuTag = addrTag;
	assign cache.cpuIndex = addrIndex;
	assign cache.cpuOffset = blockTransfer ? wordCounter : addrOffset;
	assign cache.cpuDataIn = fillWrite ? mem.dataIn : cpuWriteData;
	assign cache.cpuWriteData = fillWrite || hitWrite || upgradeWrite;
	assign cache.cpuWriteTag = fillWrite && lastWord;
	assign cache.cpuWriteState = (fillWrite && lastWord) || hitWrite || upgradeWrite;
	// a shared fill lands in forward and a sole copy in exclusive
	assign cache.cpuStateIn = (fillWrite && pendingCommand != BUS_READ_EXCLUSIVE)
		? (sharedIn ? FORWARD : EXCLUSIVE) : MODIFIED;

	// victim write-back uses the stored tag
	assign mem.address = {(state == WRITING_BACK) ? cache.cpuTagOut : addrTag,
		addrIndex, wordCounter};
	assign mem.dataOut = cache.cpuDataOut;

	assign cpuReadData = cache.cpuDataOut;

	// request only while waiting for a grant
	assign busRequest = !granted && (blockTransfer || state == UPGRADING);
	assign busCommand = busRequest ? pendingCommand : NONE;

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= WAITING_FOR_REQUEST;
			pendingCommand <= NONE;
			granted <= 1'b0;
			wordCounter <= '0;
			sweepCount <= '0;
			cpuDone <= 1'b0;
			mem.readEnabled <= 1'b0;
			mem.writeEnabled <= 1'b0;
		end else begin
			if (!sweepDone) begin
				sweepCount <= sweepCount + 1'b1;
			end
			case (state)
				WAITING_FOR_REQUEST: begin
					if (sweepDone && (cpuRead || cpuWrite)) begin
						if (cache.cpuHit && (!cpuWrite || ownsLine)) begin
							cpuDone <= 1'b1;
							state <= SERVE_REQUEST_FINISH;
						end else if (cache.cpuHit) begin
							pendingCommand <= BUS_UPGRADE;
							state <= UPGRADING;
						end else begin
							pendingCommand <= cpuWrite ? BUS_READ_EXCLUSIVE : BUS_READ;
							state <= dirtyVictim ? WRITING_BACK : READING_BLOCK;
						end
					end
				end

				// one grant and one memory transaction per word
				WRITING_BACK, READING_BLOCK: begin
					if (!granted) begin
						if (busGrant) begin
							granted <= 1'b1;
							mem.writeEnabled <= (state == WRITING_BACK);
							mem.readEnabled <= (state == READING_BLOCK);
						end
					end else if (mem.functionComplete) begin
						granted <= 1'b0;
						mem.writeEnabled <= 1'b0;
						mem.readEnabled <= 1'b0;
						wordCounter <= wordCounter + 1'b1;
						if (lastWord) begin
							// after the fill the request is served again as a hit
							state <= (state == WRITING_BACK) ? READING_BLOCK : WAITING_FOR_REQUEST;
						end
					end
				end

				UPGRADING: begin
					if (!cache.cpuHit) begin
						// line was invalidated by a snoop so fetch it again
						pendingCommand <= BUS_READ_EXCLUSIVE;
						state <= READING_BLOCK;
					end else if (busGrant) begin
						cpuDone <= 1'b1;
						state <= SERVE_REQUEST_FINISH;
					end
				end

				SERVE_REQUEST_FINISH: begin
					cpuDone <= 1'b0;
					state <= WAITING_FOR_REQUEST;
				end

				default: begin
					state <= WAITING_FOR_REQUEST;
				end
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (reset)
		!(mem.readEnabled && mem.writeEnabled));

	assert property (@(posedge clock) disable iff (reset)
		busRequest == (busCommand != NONE));

	// a pending bus request is never withdrawn before its grant
	assert property (@(posedge clock) disable iff (reset)
		busRequest && !busGrant |=> busRequest);

endmodule

/* snoopController.sv */
`timescale 1ns/10ps

module snoopController import coherencePkg::*; #(
	parameter int ADDRESS_WIDTH = DEFAULT_ADDRESS_WIDTH,
	parameter int INDEX_WIDTH = DEFAULT_INDEX_WIDTH,
	parameter int OFFSET_WIDTH = DEFAULT_OFFSET_WIDTH
) (
	input logic clock,
	input logic reset,
	input logic snoopValid,
	input logic [ADDRESS_WIDTH-1:0] snoopAddress,
	input BusCommand snoopCommand,
	output logic sharedOut,
	output logic forwardOut,
	CacheInterface.snooper cache
);

	localparam int TAG_WIDTH = ADDRESS_WIDTH - INDEX_WIDTH - OFFSET_WIDTH;

	CacheState nextState;
	logic validHit;

	assign cache.snoopTag = snoopAddress[ADDRESS_WIDTH-1 -: TAG_WIDTH];
	assign cache.snoopIndex = snoopAddress[OFFSET_WIDTH +: INDEX_WIDTH];

	assign validHit = snoopValid && cache.snoopHit;
	assign sharedOut = validHit;
	assign forwardOut = validHit && (cache.snoopStateOut == FORWARD);

	always_comb begin
		nextState = cache.snoopStateOut;
		case (snoopCommand)
			BUS_READ: begin
				// another reader: give up exclusivity, keep dirty data as owner
				case (cache.snoopStateOut)
					MODIFIED: nextState = OWNED;
					EXCLUSIVE, FORWARD: nextState = SHARED;
					default: nextState = cache.snoopStateOut;
				endcase
			end
			BUS_READ_EXCLUSIVE, BUS_UPGRADE: nextState = INVALID;
			default: nextState = cache.snoopStateOut;
		endcase
	end

	assign cache.snoopStateIn = nextState;
	assign cache.snoopWriteState = validHit && (nextState != cache.snoopStateOut);

	assert property (@(posedge clock) disable iff (reset)
		forwardOut |-> sharedOut);

endmodule

/* coherentCache.sv */
`timescale 1ns/10ps

module coherentCache import coherencePkg::*; #(
	parameter int ADDRESS_WIDTH = DEFAULT_ADDRESS_WIDTH,
	parameter int INDEX_WIDTH = DEFAULT_INDEX_WIDTH,
	parameter int OFFSET_WIDTH = DEFAULT_OFFSET_WIDTH,
	parameter int DATA_WIDTH = DEFAULT_DATA_WIDTH
) (
	input logic clock,
	input logic reset,
	input logic [ADDRESS_WIDTH-1:0] cpuAddress,
	input logic [DATA_WIDTH-1:0] cpuWriteData,
	input logic cpuRead,
	input logic cpuWrite,
	output logic [DATA_WIDTH-1:0] cpuReadData,
	output logic cpuDone,
	output logic [ADDRESS_WIDTH-1:0] memAddress,
	output logic [DATA_WIDTH-1:0] memWriteData,
	input logic [DATA_WIDTH-1:0] memReadData,
	output logic memRead,
	output logic memWrite,
	input logic memDone,
	output BusCommand busCommand,
	output logic busRequest,
	input logic busGrant,
	input logic sharedIn,
	input logic snoopValid,
	input logic [ADDRESS_WIDTH-1:0] snoopAddress,
	input BusCommand snoopCommand,
	output logic sharedOut,
	output logic forwardOut
);

	MemoryInterface #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.DATA_WIDTH(DATA_WIDTH)
	) memoryBus ();

	CacheInterface #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.INDEX_WIDTH(INDEX_WIDTH),
		.OFFSET_WIDTH(OFFSET_WIDTH),
		.DATA_WIDTH(DATA_WIDTH)
	) cacheBus ();

	assign memAddress = memoryBus.address;
	assign memWriteData = memoryBus.dataOut;
	assign memRead = memoryBus.readEnabled;
	assign memWrite = memoryBus.writeEnabled;
	assign memoryBus.dataIn = memReadData;
	assign memoryBus.functionComplete = memDone;

	cacheStore #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.INDEX_WIDTH(INDEX_WIDTH),
		.OFFSET_WIDTH(OFFSET_WIDTH),
		.DATA_WIDTH(DATA_WIDTH)
	) storeUnit (
		.clock(clock),
		.reset(reset),
		.store(cacheBus.store)
	);

	cpuController #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.INDEX_WIDTH(INDEX_WIDTH),
		.OFFSET_WIDTH(OFFSET_WIDTH),
		.DATA_WIDTH(DATA_WIDTH)
	) cpuControl (
		.clock(clock),
		.reset(reset),
		.cpuAddress(cpuAddress),
		.cpuWriteData(cpuWriteData),
		.cpuRead(cpuRead),
		.cpuWrite(cpuWrite),
		.cpuReadData(cpuReadData),
		.cpuDone(cpuDone),
		.mem(memoryBus.master),
		.cache(cacheBus.controller),
		.busCommand(busCommand),
		.busRequest(busRequest),
		.busGrant(busGrant),
		.sharedIn(sharedIn)
	);

	snoopController #(
		.ADDRESS_WIDTH(ADDRESS_WIDTH),
		.INDEX_WIDTH(INDEX_WIDTH),
		.OFFSET_WIDTH(OFFSET_WIDTH)
	) snoopControl (
		.clock(clock),
		.reset(reset),
		.snoopValid(snoopValid),
		.snoopAddress(snoopAddress),
		.snoopCommand(snoopCommand),
		.sharedOut(sharedOut),
		.forwardOut(forwardOut),
		.cache(cacheBus.snooper)
	);

endmodule

/* coherentCacheTb.sv */
`timescale 1ns/10ps

module coherentCacheTb import coherencePkg::*; ();

	localparam int OPERATIONS = 400;
	localparam int CYCLE_LIMIT = OPERATIONS * 40;

	logic clock = 1'b0;
	logic reset;
	logic [15:0] cpuAddress;
	logic [15:0] cpuWriteData;
	logic cpuRead;
	logic cpuWrite;
	logic [15:0] cpuReadData;
	logic cpuDone;
	logic [15:0] memAddress;
	logic [15:0] memWriteData;
	logic [15:0] memReadData;
	logic memRead;
	logic memWrite;
	logic memDone;
	BusCommand busCommand;
	logic busRequest;
	logic busGrant;
	logic sharedIn;
	logic snoopValid;
	logic [15:0] snoopAddress;
	BusCommand snoopCommand;
	logic sharedOut;
	logic forwardOut;

	logic [31:0] lfsrState;
	int cycleCount = 0;
	int grantDelay;
	int memDelay;
	logic [15:0] memoryWords [65536];
	logic [9:0] modelTag [16];
	CacheState modelState [16];
	logic [15:0] modelData [64];
	logic [15:0] writeBackAddress [$];
	logic [15:0] writeBackData [$];

	coherentCache dut_i (.*);

	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount == CYCLE_LIMIT) begin
			failRun($sformatf("run did not finish within %0d cycles", CYCLE_LIMIT));
		end
	end

	// x^32 + x^22 + x^2 + x + 1 stepped once per bit
	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		logic feedback;
		int i;
		value = '0;
		for (i = 0; i < count; i++) begin
			feedback = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
			lfsrState = {lfsrState[30:0], feedback};
			value = {value[30:0], feedback};
		end
		return value;
	endfunction

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic compareValue(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		if (actual !== expected) begin
			failRun($sformatf("FAILED %s: actual 0x%0h expected 0x%0h", name, actual, expected));
		end
	endtask

	// arbiter and memory side for one cycle
	task automatic serviceBus(input BusCommand expectedCommand, inout logic sawRequest);
		if (busGrant) begin
			busGrant = 1'b0;
		end else if (busRequest) begin
			sawRequest = 1'b1;
			compareValue("busCommand", busCommand, expectedCommand);
			if (grantDelay == 0) begin
				busGrant = 1'b1;
				grantDelay = int'(randomBits(2));
			end else begin
				grantDelay--;
			end
		end else begin
			compareValue("busCommand", busCommand, NONE);
		end
		if (memDone) begin
			memDone = 1'b0;
		end else if ((memRead || memWrite) && memDelay > 0) begin
			memDelay--;
		end else if (memRead) begin
			memReadData = memoryWords[memAddress];
			memDone = 1'b1;
			memDelay = int'(randomBits(2));
		end else if (memWrite) begin
			if (writeBackAddress.size() == 0) begin
				failRun("memory write seen without a dirty line to write back");
			end
			compareValue("memAddress", memAddress, writeBackAddress.pop_front());
			compareValue("memWriteData", memWriteData, writeBackData.pop_front());
			memoryWords[memAddress] = memWriteData;
			memDone = 1'b1;
			memDelay = int'(randomBits(2));
		end
	endtask

	task automatic cpuAccess(input logic isWrite, input logic [15:0] address,
			input logic [15:0] data);
		logic [9:0] tag;
		logic [3:0] index;
		logic hit;
		logic fast;
		logic shared;
		logic sawRequest;
		BusCommand expectedCommand;
		int waited;
		int k;
		tag = address[15:6];
		index = address[5:2];
		hit = (modelState[index] != INVALID) && (modelTag[index] == tag);
		fast = hit && (modelState[index] == EXCLUSIVE || modelState[index] == MODIFIED);
		shared = 1'(randomBits(1));
		if (hit && (!isWrite || fast)) begin
			expectedCommand = NONE;
		end else if (hit) begin
			expectedCommand = BUS_UPGRADE;
		end else begin
			expectedCommand = isWrite ? BUS_READ_EXCLUSIVE : BUS_READ;
		end
		if (!hit && (modelState[index] == MODIFIED || modelState[index] == OWNED)) begin
			for (k = 0; k < 4; k++) begin
				writeBackAddress.push_back({modelTag[index], index, k[1:0]});
				writeBackData.push_back(modelData[{index, k[1:0]}]);
			end
		end
		// victim and new block never share an address so memory is current here
		if (!hit) begin
			for (k = 0; k < 4; k++) begin
				modelData[{index, k[1:0]}] = memoryWords[{tag, index, k[1:0]}];
			end
			modelTag[index] = tag;
			modelState[index] = shared ? FORWARD : EXCLUSIVE;
		end
		if (isWrite) begin
			modelData[address[5:0]] = data;
			modelState[index] = MODIFIED;
		end

		cpuAddress = address;
		cpuWriteData = data;
		cpuRead = !isWrite;
		cpuWrite = isWrite;
		sharedIn = shared;
		sawRequest = 1'b0;
		@(posedge clock);
		#1;
		waited = 1;
		while (!cpuDone) begin
			serviceBus(expectedCommand, sawRequest);
			@(posedge clock);
			#1;
			waited++;
		end
		if (!isWrite) begin
			compareValue("cpuReadData", cpuReadData, modelData[address[5:0]]);
		end
		if (fast) begin
			compareValue("cpuDone latency", waited, 1);
		end
		compareValue("busRequest", sawRequest, expectedCommand != NONE);
		compareValue("write-back count", writeBackAddress.size(), 0);
		busGrant = 1'b0;
		memDone = 1'b0;
		cpuRead = 1'b0;
		cpuWrite = 1'b0;
		@(posedge clock);
		#1;
	endtask

	task automatic snoopAccess(input BusCommand command, input logic [15:0] address);
		logic [3:0] index;
		logic hit;
		index = address[5:2];
		hit = (modelState[index] != INVALID) && (modelTag[index] == address[15:6]);
		snoopAddress = address;
		snoopCommand = command;
		snoopValid = 1'b1;
		#1;
		compareValue("sharedOut", sharedOut, hit);
		compareValue("forwardOut", forwardOut, hit && modelState[index] == FORWARD);
		@(posedge clock);
		#1;
		snoopValid = 1'b0;
		snoopCommand = NONE;
		if (hit && command == BUS_READ) begin
			if (modelState[index] == MODIFIED) begin
				modelState[index] = OWNED;
			end else if (modelState[index] == EXCLUSIVE || modelState[index] == FORWARD) begin
				modelState[index] = SHARED;
			end
		end else if (hit) begin
			modelState[index] = INVALID;
		end
	endtask

	initial begin
		logic [2:0] kind;
		logic [1:0] tagBits;
		logic [1:0] indexBits;
		logic [1:0] offsetBits;
		logic [15:0] address;
		int i;
		reset = 1'b1;
		cpuAddress = '0;
		cpuWriteData = '0;
		cpuRead = 1'b0;
		cpuWrite = 1'b0;
		memReadData = '0;
		memDone = 1'b0;
		busGrant = 1'b0;
		sharedIn = 1'b0;
		snoopValid = 1'b0;
		snoopAddress = '0;
		snoopCommand = NONE;
		lfsrState = 32'h6c948141;
		for (i = 0; i < 65536; i++) begin
			memoryWords[i] = {i[7:0], i[15:8]} ^ 16'hc35a;
		end
		for (i = 0; i < 16; i++) begin
			modelState[i] = INVALID;
			modelTag[i] = '0;
		end
		grantDelay = int'(randomBits(2));
		memDelay = int'(randomBits(2));
		repeat (4) @(posedge clock);
		#1;
		reset = 1'b0;
		compareValue("cpuDone", cpuDone, 0);
		compareValue("memRead", memRead, 0);
		compareValue("memWrite", memWrite, 0);
		compareValue("busRequest", busRequest, 0);
		compareValue("busCommand", busCommand, NONE);
		// the store sweeps one line per cycle before snoops see clean states
		repeat (16) @(posedge clock);
		#1;

		for (i = 0; i < OPERATIONS; i++) begin
			kind = 3'(randomBits(3));
			tagBits = 2'(randomBits(2));
			indexBits = 2'(randomBits(2));
			offsetBits = 2'(randomBits(2));
			// four tags over four lines keeps evictions frequent
			address = {8'h35, tagBits, 2'b01, indexBits, offsetBits};
			if (kind < 3) begin
				cpuAccess(1'b0, address, '0);
			end else if (kind < 6) begin
				cpuAccess(1'b1, address, 16'(randomBits(16)));
			end else if (kind == 6) begin
				snoopAccess(BUS_READ, address);
			end else begin
				snoopAccess(randomBits(1) ? BUS_UPGRADE : BUS_READ_EXCLUSIVE, address);
			end
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

/* all.f */
coherencePkg.sv
memoryIf.sv
cacheIf.sv
cacheStore.sv
cpuController.sv
snoopController.sv
coherentCache.sv
coherentCacheTb.sv

/* Bender.yml */
package:
  name: coherent_cache

sources:
  - coherencePkg.sv
  - memoryIf.sv
  - cacheIf.sv
  - cacheStore.sv
  - cpuController.sv
  - snoopController.sv
  - coherentCache.sv
  - target: simulation
    files:
      - coherentCacheTb.sv
